/* testbench/jump_game_props.sv */
`timescale 1ns/1ps

module jump_game_props (
	input logic                  clk,
	input logic                  rst,
	input game_pkg::coord_t      char_x,
	input logic                  land,
	input game_pkg::game_state_e state
);

	int fail_count = 0;  // failed assertions so far

	x_in_bounds: assert property (@(posedge clk) disable iff (rst)
		char_x >= game_pkg::X_MIN && char_x <= game_pkg::X_MAX)
	else begin
		fail_count++;
		$error("character x left the allowed range");
	end

	land_one_cycle: assert property (@(posedge clk) disable iff (rst) land |=> !land)
	else begin
		fail_count++;
		$error("landing pulse was high for two cycles in a row");
	end

	over_sticky: assert property (@(posedge clk) disable iff (rst)
		state == game_pkg::OVER |=> state == game_pkg::OVER)
	else begin
		fail_count++;
		$error("game went back from over to playing without a reset");
	end

endmodule

bind doodler_motion jump_game_props u_props (
	.clk    (clk),
	.rst    (rst),
	.char_x (char_x),
	.land   (land),
	.state  (state)
);

/* include/jump_game_model.svh */
`ifndef JUMP_GAME_MODEL_SVH
`define JUMP_GAME_MODEL_SVH

// mirror of the game registers
logic [7:0]                         m_jump_ctr;
game_pkg::coord_t                   m_char_x;
game_pkg::coord_t                   m_char_y;
logic                               m_land;
game_pkg::game_state_e              m_state;
game_pkg::platform_arr_t            m_plat;
logic [9:0]                         m_seed;
game_pkg::coord_t                   m_spawn;
logic [game_pkg::NUM_PLATFORMS-1:0] m_hit_q;  // hits one tick back

function automatic void model_reset();
	m_jump_ctr = '0;
	m_char_x   = game_pkg::coord_t'(game_pkg::CHAR_START_X);
	m_char_y   = game_pkg::coord_t'(game_pkg::CHAR_START_Y);
	m_land     = 1'b0;
	m_state    = game_pkg::PLAYING;
	m_plat     = game_pkg::PLAT_START;
	m_seed     = '0;
	m_spawn    = '0;
	m_hit_q    = '0;
endfunction

// foot point one row into each platform top
function automatic logic [game_pkg::NUM_PLATFORMS-1:0] model_hit();
	logic [game_pkg::NUM_PLATFORMS-1:0] h;
	int fx;
	int fy;
	fx = int'(m_char_x) + game_pkg::FOOT_OFFSET_X;
	fy = int'(m_char_y) + game_pkg::CHAR_SIZE;
	for (int i = 0; i < game_pkg::NUM_PLATFORMS; i++) begin
		h[i] = (fx >= int'(m_plat[i].x) - game_pkg::PLAT_HALF_WIDTH) &&
			(fx <= int'(m_plat[i].x) + game_pkg::PLAT_HALF_WIDTH) &&
			(fy == int'(m_plat[i].y) + 1);
	end
	return h;
endfunction

// one game tick, all next values from the current ones
function automatic void step_model(input logic l, input logic r);
	logic [game_pkg::NUM_PLATFORMS-1:0] h;
	logic [7:0]              n_ctr;
	game_pkg::coord_t        n_y;
	logic                    n_land;
	game_pkg::game_state_e   n_state;
	game_pkg::platform_arr_t n_plat;
	h       = model_hit();
	n_ctr   = m_jump_ctr + 8'd1;
	n_y     = m_char_y;
	n_land  = m_land;
	n_state = m_state;
	n_plat  = m_plat;
	if (!m_land) begin
		if (m_jump_ctr < game_pkg::RISE_TICKS) begin
			n_y = game_pkg::coord_t'(m_char_y - game_pkg::JUMP_STEP);
		end else if (m_jump_ctr > game_pkg::RISE_TICKS) begin
			n_y    = game_pkg::coord_t'(m_char_y + game_pkg::JUMP_STEP);
			n_land = |h;
		end
	end else begin
		for (int i = 0; i < game_pkg::NUM_PLATFORMS; i++) begin
			if (m_hit_q[i] && game_pkg::plat_kind(i) == game_pkg::PLAT_SAFE)
				n_y = game_pkg::coord_t'(m_plat[i].y - (game_pkg::CHAR_SIZE - 1));
			else if (m_hit_q[i])
				n_state = game_pkg::OVER;
		end
		n_land = 1'b0;
		n_ctr  = '0;
	end
	if (r && m_char_x != game_pkg::X_MAX)
		m_char_x = game_pkg::coord_t'(m_char_x + game_pkg::MOVE_STEP);
	else if (!r && l && m_char_x != game_pkg::X_MIN)
		m_char_x = game_pkg::coord_t'(m_char_x - game_pkg::MOVE_STEP);
	for (int i = 0; i < game_pkg::NUM_PLATFORMS; i++) begin
		if (m_plat[i].y > game_pkg::WRAP_LIMIT) begin
			n_plat[i].y = game_pkg::coord_t'(game_pkg::RESPAWN_Y);
			n_plat[i].x = m_spawn;
		end else if (m_land) begin
			n_plat[i].y = game_pkg::coord_t'(m_plat[i].y + game_pkg::SCROLL_STEP);
		end
	end
	m_spawn    = game_pkg::coord_t'((int'(m_seed) * game_pkg::RNG_MUL) % game_pkg::RNG_MOD
		+ game_pkg::RNG_BASE);
	m_seed     = m_seed + 10'd1;
	m_hit_q    = h;
	m_jump_ctr = n_ctr;
	m_char_y   = n_y;
	m_land     = n_land;
	m_state    = n_state;
	m_plat     = n_plat;
endfunction

// colour the DUT should show for one pixel
function automatic game_pkg::color_t expected_rgb(input logic b, input game_pkg::coord_t h,
	input game_pkg::coord_t v);
	logic playing;
	logic safe_px;
	logic hazard_px;
	playing   = (m_state == game_pkg::PLAYING);
	safe_px   = 1'b0;
	hazard_px = 1'b0;
	for (int i = 0; i < game_pkg::NUM_PLATFORMS; i++) begin
		if (int'(h) >= int'(m_plat[i].x) - game_pkg::PLAT_HALF_WIDTH &&
			int'(h) <= int'(m_plat[i].x) + game_pkg::PLAT_HALF_WIDTH &&
			int'(v) >= int'(m_plat[i].y) &&
			int'(v) <= int'(m_plat[i].y) + game_pkg::PLAT_HEIGHT) begin
			if (game_pkg::plat_kind(i) == game_pkg::PLAT_SAFE)
				safe_px = 1'b1;
			else
				hazard_px = 1'b1;
		end
	end
	if (!b)
		return game_pkg::COL_BLACK;
	if (playing && int'(h) >= int'(m_char_x) && int'(h) < int'(m_char_x) + game_pkg::CHAR_SIZE &&
		int'(v) >= int'(m_char_y) && int'(v) < int'(m_char_y) + game_pkg::CHAR_SIZE)
		return game_pkg::COL_BODY;
	if (playing && safe_px)
		return game_pkg::COL_SAFE;
	if (playing && hazard_px)
		return game_pkg::COL_HAZARD;
	if (!playing && h >= game_pkg::END_PANEL.x_lo && h <= game_pkg::END_PANEL.x_hi &&
		v >= game_pkg::END_PANEL.y_lo && v <= game_pkg::END_PANEL.y_hi)
		return game_pkg::COL_BLACK;
	return game_pkg::COL_WHITE;
endfunction

`endif

/* testbench/jump_game_tb.sv */
`timescale 1ns/1ps

module jump_game_tb;

	localparam int RUN_TICKS    = 4000;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYCLES   = 5000;  // run plus reset, about 25% margin

	logic             clk;
	logic             rst;
	logic             bright;
	logic             left;
	logic             right;
	game_pkg::coord_t h_count;
	game_pkg::coord_t v_count;
	game_pkg::color_t rgb;

	integer seed = 32'hc53e8c7b;
	int     tick;
	int     cycles;
	int     checks;
	int     errors;

	`include "jump_game_model.svh"

	jump_game_top UUT (
		.clk     (clk),
		.rst     (rst),
		.bright  (bright),
		.left    (left),
		.right   (right),
		.h_count (h_count),
		.v_count (v_count),
		.rgb     (rgb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// lowest platform of one kind still under the foot, else the first of that kind
	function automatic int pick_platform(input logic hazard);
		int k;
		k = hazard ? game_pkg::HAZARD_FIRST : 0;
		for (int i = 0; i < game_pkg::NUM_PLATFORMS; i++) begin
			if ((i >= game_pkg::HAZARD_FIRST) == hazard &&
				int'(m_plat[i].y) >= int'(m_char_y) + game_pkg::CHAR_SIZE &&
				m_plat[i].y < m_plat[k].y)
				k = i;
		end
		return k;
	endfunction

	task automatic steer(input logic hazard);
		int tx;
		tx = int'(m_plat[pick_platform(hazard)].x) - game_pkg::FOOT_OFFSET_X;
		right = (int'(m_char_x) + 1 < tx);
		left  = (int'(m_char_x) > tx + 1);
	endtask

	// fixed phases first, then steering and random presses
	task automatic drive_buttons();
		int r;
		r     = $random(seed);
		left  = 1'b0;
		right = 1'b0;
		if (tick >= 300 && tick < 700)
			right = 1'b1;  // runs into the right bound
		else if (tick >= 700 && tick < 1100)
			left = 1'b1;
		else if ((tick >= 1100 && tick < 2000) || (tick >= 2600 && tick < 3200))
			steer(1'b0);
		else if (tick >= 2000 && tick < 2600) begin
			left  = r[0];
			right = r[1];
		end else if (tick >= 3200)
			steer(1'b1);
	endtask

	task automatic drive_probe();
		int r;
		int k;
		r      = $random(seed);
		k      = int'(r[9:7]) % game_pkg::NUM_PLATFORMS;
		bright = (r[6:4] != 3'd0);
		case (r[2:0])
			3'd0, 3'd1: begin  // inside the square
				h_count = game_pkg::coord_t'(int'(m_char_x) + int'(r[15:10]));
				v_count = game_pkg::coord_t'(int'(m_char_y) + int'(r[21:16]));
			end
			3'd2, 3'd3: begin  // on platform k
				h_count = game_pkg::coord_t'(int'(m_plat[k].x) - 50 + int'(r[16:10]) % 101);
				v_count = game_pkg::coord_t'(int'(m_plat[k].y) + int'(r[20:17]));
			end
			3'd4: begin
				h_count = game_pkg::coord_t'(100 + int'(r[19:10]) % 701);
				v_count = game_pkg::coord_t'(int'(r[29:20]) % 526);
			end
			default: begin
				h_count = r[19:10];
				v_count = r[29:20];
			end
		endcase
	endtask

	task automatic check_pixel();
		game_pkg::color_t exp;
		exp    = expected_rgb(bright, h_count, v_count);
		checks = checks + 1;
		assert (rgb === exp)
		else begin
			errors = errors + 1;
			$display("[ERROR] rgb expected %h actual %h at tick %0d", exp, rgb, tick);
		end
	endtask

	// stimulus and final report
	initial begin
		int total;
		rst     = 1'b1;
		bright  = 1'b0;
		left    = 1'b0;
		right   = 1'b0;
		h_count = '0;
		v_count = '0;
		tick    = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		while (tick < RUN_TICKS) begin
			drive_buttons();
			drive_probe();
			@(posedge clk);
			#1;
			tick = tick + 1;
		end
		@(posedge clk);
		#1;
		total = errors + UUT.u_motion.u_props.fail_count;
		$display("checks %0d, rgb errors %0d, assertion errors %0d", checks, errors,
			UUT.u_motion.u_props.fail_count);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// compare mid-cycle, step the model on each edge
	initial begin
		checks = 0;
		errors = 0;
		model_reset();
		@(negedge rst);
		forever begin
			@(negedge clk);
			check_pixel();
			@(posedge clk);
			step_model(left, right);
		end
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("timeout after %0d cycles, the run did not reach its end", cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* verilog/doodler_motion.sv */
`timescale 1ns/1ps

module doodler_motion (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               left,
	input  logic                               right,
	input  logic [game_pkg::NUM_PLATFORMS-1:0] hit,
	input  game_pkg::platform_arr_t            platforms,
	output game_pkg::coord_t                   char_x,
	output game_pkg::coord_t                   char_y,
	output logic                               land,
	output game_pkg::game_state_e              state
);

	logic [7:0]                         jump_ctr;  // wraps, so a missed fall rises again
	logic [game_pkg::NUM_PLATFORMS-1:0] hit_q;     // hits that raised land
	game_pkg::coord_t                   snap_y;
	logic                               hazard_hit;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hit_q <= '0;
		end else begin
			hit_q <= hit;
		end
	end

	// landing target from the registered hits, last safe index wins
	always_comb begin
		snap_y     = char_y;
		hazard_hit = 1'b0;
		for (int i = 0; i < game_pkg::NUM_PLATFORMS; i++) begin
			if (hit_q[i]) begin
				if (game_pkg::plat_kind(i) == game_pkg::PLAT_SAFE)
					snap_y = platforms[i].y - game_pkg::coord_t'(game_pkg::CHAR_SIZE - 1);
				else
					hazard_hit = 1'b1;
			end
		end
	end

	// vertical motion, landing pulse and game state
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			jump_ctr <= '0;
			char_y   <= game_pkg::coord_t'(game_pkg::CHAR_START_Y);
			land     <= 1'b0;
			state    <= game_pkg::PLAYING;
		end else if (!land) begin
			jump_ctr <= jump_ctr + 8'd1;
			if (jump_ctr < 8'(game_pkg::RISE_TICKS)) begin
				char_y <= char_y - game_pkg::coord_t'(game_pkg::JUMP_STEP);  // rising
			end else if (jump_ctr > 8'(game_pkg::RISE_TICKS)) begin
				char_y <= char_y + game_pkg::coord_t'(game_pkg::JUMP_STEP);
				land   <= |hit;  // only caught on the way down
			end
		end else begin
			char_y   <= snap_y;
			jump_ctr <= '0;
			land     <= 1'b0;
			if (hazard_hit)
				state <= game_pkg::OVER;  // sticky until reset
		end
	end

	// buttons, right has priority
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			char_x <= game_pkg::coord_t'(game_pkg::CHAR_START_X);
		end else if (right) begin
			if (char_x != game_pkg::coord_t'(game_pkg::X_MAX))
				char_x <= char_x + game_pkg::coord_t'(game_pkg::MOVE_STEP);
		end else if (left) begin
			if (char_x != game_pkg::coord_t'(game_pkg::X_MIN))
				char_x <= char_x - game_pkg::coord_t'(game_pkg::MOVE_STEP);
		end
	end

endmodule

/* verilog/game_pkg.sv */
package game_pkg;

	typedef logic [9:0]  coord_t;  // screen coordinate
	typedef logic [11:0] color_t;  // 4 bits each of r, g, b

	localparam int NUM_PLATFORMS = 5;
	localparam int HAZARD_FIRST  = 3;  // index 3 and up are hazards

	typedef struct packed {
		coord_t x;  // horizontal centre
		coord_t y;  // top row
	} platform_t;

	typedef platform_t [NUM_PLATFORMS-1:0] platform_arr_t;

	// inclusive screen rectangle
	typedef struct packed {
		coord_t x_lo;
		coord_t x_hi;
		coord_t y_lo;
		coord_t y_hi;
	} rect_t;

	typedef enum logic {
		PLAYING,
		OVER
	} game_state_e;

	typedef enum logic {
		PLAT_SAFE,
		PLAT_HAZARD
	} plat_kind_e;

	// platform and character geometry
	localparam int PLAT_HALF_WIDTH = 50;
	localparam int PLAT_HEIGHT     = 15;  // rows below the top row
	localparam int CHAR_SIZE       = 64;
	localparam int FOOT_OFFSET_X   = 32;  // foot column inside the square

	// motion
	localparam int RISE_TICKS  = 64;
	localparam int JUMP_STEP   = 3;
	localparam int MOVE_STEP   = 2;
	localparam int X_MIN       = 160;
	localparam int X_MAX       = 766;
	localparam int SCROLL_STEP = 20;
	localparam int WRAP_LIMIT  = 510;
	localparam int RESPAWN_Y   = 50;

	// spawn x = (seed * mul mod m) + base, lands in 190..730
	localparam int RNG_MUL  = 437;
	localparam int RNG_MOD  = 541;
	localparam int RNG_BASE = 190;

	localparam int CHAR_START_X = 464;
	localparam int CHAR_START_Y = 452;

	localparam platform_arr_t PLAT_START = '{
		0: '{x: 10'd197, y: 10'd100},
		1: '{x: 10'd624, y: 10'd312},
		2: '{x: 10'd588, y: 10'd473},
		3: '{x: 10'd500, y: 10'd234},
		4: '{x: 10'd217, y: 10'd466}
	};

	localparam rect_t END_PANEL = '{x_lo: 10'd100, x_hi: 10'd800, y_lo: 10'd0, y_hi: 10'd525};

	localparam color_t COL_BLACK  = 12'h000;
	localparam color_t COL_WHITE  = 12'hFFF;
	localparam color_t COL_SAFE   = 12'h82D;
	localparam color_t COL_HAZARD = 12'hC33;
	localparam color_t COL_BODY   = 12'h0F0;

	// platform class by index
	function automatic plat_kind_e plat_kind(input int idx);
		return (idx >= HAZARD_FIRST) ? PLAT_HAZARD : PLAT_SAFE;
	endfunction

endpackage

/* verilog/jump_game_top.sv */
`timescale 1ns/1ps

module jump_game_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              bright,
	input  logic              left,
	input  logic              right,
	input  game_pkg::coord_t  h_count,
	input  game_pkg::coord_t  v_count,
	output game_pkg::color_t  rgb
);

	game_pkg::platform_arr_t            platforms;
	game_pkg::coord_t                   char_x;
	game_pkg::coord_t                   char_y;
	game_pkg::game_state_e              state;
	logic                               land;  // one-cycle landing pulse
	logic [game_pkg::NUM_PLATFORMS-1:0] hit;

	doodler_motion u_motion (
		.clk       (clk),
		.rst       (rst),
		.left      (left),
		.right     (right),
		.hit       (hit),
		.platforms (platforms),
		.char_x    (char_x),
		.char_y    (char_y),
		.land      (land),
		.state     (state)
	);

	landing_detect u_detect (
		.char_x    (char_x),
		.char_y    (char_y),
		.platforms (platforms),
		.hit       (hit)
	);

	platform_bank u_platforms (
		.clk       (clk),
		.rst       (rst),
		.land      (land),
		.platforms (platforms)
	);

	pixel_painter u_painter (
		.bright    (bright),
		.h_count   (h_count),
		.v_count   (v_count),
		.char_x    (char_x),
		.char_y    (char_y),
		.platforms (platforms),
		.state     (state),
		.rgb       (rgb)
	);

endmodule

/* verilog/landing_detect.sv */
`timescale 1ns/1ps

module landing_detect (
	input  game_pkg::coord_t                  char_x,
	input  game_pkg::coord_t                  char_y,
	input  game_pkg::platform_arr_t           platforms,
	output logic [game_pkg::NUM_PLATFORMS-1:0] hit
);

	logic [10:0] foot_x;  // one bit of headroom over coord_t
	logic [10:0] foot_y;

	assign foot_x = char_x + 11'(game_pkg::FOOT_OFFSET_X);
	assign foot_y = char_y + 11'(game_pkg::CHAR_SIZE);

	// foot point exactly one row into the platform top, within its width
	always_comb begin
		for (int i = 0; i < game_pkg::NUM_PLATFORMS; i++) begin
			hit[i] = (foot_x + 11'(game_pkg::PLAT_HALF_WIDTH) >= platforms[i].x) &&
				(foot_x <= platforms[i].x + 11'(game_pkg::PLAT_HALF_WIDTH)) &&
				(foot_y == platforms[i].y + 11'd1);
		end
	end

endmodule

/* verilog/pixel_painter.sv */
`timescale 1ns/1ps

module pixel_painter (
	input  logic                  bright,
	input  game_pkg::coord_t      h_count,
	input  game_pkg::coord_t      v_count,
	input  game_pkg::coord_t      char_x,
	input  game_pkg::coord_t      char_y,
	input  game_pkg::platform_arr_t platforms,
	input  game_pkg::game_state_e state,
	output game_pkg::color_t      rgb
);

	logic in_char;
	logic on_safe;
	logic on_hazard;
	logic in_panel;

	// character drawn as one filled square
	assign in_char = (h_count >= char_x) &&
		(h_count <= char_x + 11'(game_pkg::CHAR_SIZE - 1)) &&
		(v_count >= char_y) &&
		(v_count <= char_y + 11'(game_pkg::CHAR_SIZE - 1));

	assign in_panel = (h_count >= game_pkg::END_PANEL.x_lo) &&
		(h_count <= game_pkg::END_PANEL.x_hi) &&
		(v_count >= game_pkg::END_PANEL.y_lo) &&
		(v_count <= game_pkg::END_PANEL.y_hi);

	always_comb begin
		on_safe   = 1'b0;
		on_hazard = 1'b0;
		for (int i = 0; i < game_pkg::NUM_PLATFORMS; i++) begin
			if ((h_count + 11'(game_pkg::PLAT_HALF_WIDTH) >= platforms[i].x) &&
				(h_count <= platforms[i].x + 11'(game_pkg::PLAT_HALF_WIDTH)) &&
				(v_count >= platforms[i].y) &&
				(v_count <= platforms[i].y + 11'(game_pkg::PLAT_HEIGHT))) begin
				if (game_pkg::plat_kind(i) == game_pkg::PLAT_SAFE)
					on_safe = 1'b1;
				else
					on_hazard = 1'b1;
			end
		end
	end

	// colour priority, blanking first
	always_comb begin
		if (!bright)
			rgb = game_pkg::COL_BLACK;
		else if (state == game_pkg::PLAYING && in_char)
			rgb = game_pkg::COL_BODY;
		else if (state == game_pkg::PLAYING && on_safe)
			rgb = game_pkg::COL_SAFE;
		else if (state == game_pkg::PLAYING && on_hazard)
			rgb = game_pkg::COL_HAZARD;
		else if (state == game_pkg::OVER && in_panel)
			rgb = game_pkg::COL_BLACK;  // end panel
		else
			rgb = game_pkg::COL_WHITE;
	end

endmodule

/* verilog/platform_bank.sv */
`timescale 1ns/1ps

module platform_bank (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    land,
	output game_pkg::platform_arr_t platforms
);

	logic [9:0]       seed;   // free running, one step per tick
	game_pkg::coord_t spawn;  // x for the next respawn

	// spawn position generator
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			seed  <= '0;
			spawn <= '0;
		end else begin
			seed  <= seed + 10'd1;
			spawn <= game_pkg::coord_t'((32'(seed) * game_pkg::RNG_MUL) % game_pkg::RNG_MOD
				+ game_pkg::RNG_BASE);
		end
	end

	// scroll on landing, respawn wins over scroll
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			platforms <= game_pkg::PLAT_START;
		end else begin
			for (int i = 0; i < game_pkg::NUM_PLATFORMS; i++) begin
				if (platforms[i].y > game_pkg::coord_t'(game_pkg::WRAP_LIMIT)) begin
					platforms[i].y <= game_pkg::coord_t'(game_pkg::RESPAWN_Y);  // back to the top
					platforms[i].x <= spawn;
				end else if (land) begin
					platforms[i].y <= platforms[i].y + game_pkg::coord_t'(game_pkg::SCROLL_STEP);
				end
			end
		end
	end

endmodule

/* vlog.f */
+incdir+include
verilog/game_pkg.sv
verilog/landing_detect.sv
verilog/platform_bank.sv
verilog/doodler_motion.sv
verilog/pixel_painter.sv
verilog/jump_game_top.sv
testbench/jump_game_props.sv
testbench/jump_game_tb.sv
